//--- lab_defines.svh
`ifndef LAB_DEFINES_SVH
`define LAB_DEFINES_SVH

//----------------------------------------
// Board

`define LAB_CLK_MHZ   50          // System clock rate
`define LAB_W_KEY     4
`define LAB_W_SW      8
`define LAB_W_DIGIT   4

//----------------------------------------
// Datapath and timing

`define LAB_W_SAMPLE  24          // INMP441 word
`define LAB_W_LEVEL   16
`define LAB_SCK_DIV   4           // clk cycles per sck half period
`define LAB_SCAN_DIV  16          // clk cycles per digit, kept short for simulation

`define EMULATE_DYNAMIC_SEG 0     // 1 gives combinational HEX outputs

`endif

//--- lab_pkg.sv
package lab_pkg;

    //----------------------------------------
    // What the four digits show

    typedef enum logic [1:0]
    {
        mode_raw   = 2'd0,        // Top bits of the mic word
        mode_level = 2'd1,        // Absolute level of the last sample
        mode_peak  = 2'd2         // Largest level since clear
    } display_mode_t;

    //----------------------------------------
    // Meter control FSM

    typedef enum logic
    {
        st_live = 1'b0,           // Meter follows new samples
        st_hold = 1'b1            // Meter frozen
    } ctrl_state_t;

endpackage

//--- meter_if.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

interface meter_if;

    logic                          sample_valid;   // One-cycle strobe
    logic [`LAB_W_SAMPLE - 1:0]    sample;
    logic                          hold;
    logic                          clear_peak;     // One-cycle pulse
    logic [`LAB_W_LEVEL  - 1:0]    level;
    logic [`LAB_W_LEVEL  - 1:0]    peak;

    modport ctrl  (output hold, clear_peak, input level, peak);

    modport meter (input sample_valid, sample, hold, clear_peak, output level, peak);

endinterface

//--- mic_i2s_receiver.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

module mic_i2s_receiver
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sd,
    output logic                         sck,
    output logic                         ws,
    output logic                         lr,
    meter_if                             bus,
    output logic [`LAB_W_SAMPLE - 1:0]   value
);

    localparam w_div     = $clog2 (`LAB_SCK_DIV + 1);
    localparam first_bit = 6'd1;                    // MSB one sck after ws falls
    localparam last_bit  = 6'(`LAB_W_SAMPLE);

    logic [w_div - 1:0]            div_cnt;
    logic                          half_done;
    logic [5:0]                    bit_cnt;         // sck period within the frame
    logic                          take_bit;
    logic                          last_take;
    logic [`LAB_W_SAMPLE - 2:0]    shift;
    logic [`LAB_W_SAMPLE - 1:0]    sample;
    logic                          sample_valid;

    //----------------------------------------
    // sck divider and frame counter

    assign half_done = (div_cnt == w_div'(`LAB_SCK_DIV - 1));

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else if (half_done)
        begin
            div_cnt <= '0;
            sck     <= ~ sck;
            if (sck)
                bit_cnt <= bit_cnt + 6'd1;          // New period on the falling edge
        end
        else
        begin
            div_cnt <= div_cnt + w_div'(1);
        end

    assign ws = bit_cnt [5];                        // Low for the first 32 periods
    assign lr = 1'b0;                               // Mic talks in the left slot

    //----------------------------------------
    // Left slot capture

    assign take_bit  = half_done & ~ sck & ~ ws
                     & (bit_cnt >= first_bit) & (bit_cnt <= last_bit);
    assign last_take = take_bit & (bit_cnt == last_bit);

    always_ff @ (posedge clk)
        if (take_bit)
            shift <= { shift [`LAB_W_SAMPLE - 3:0], sd };

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            sample_valid <= 1'b0;
            sample       <= '0;
        end
        else
        begin
            sample_valid <= last_take;
            if (last_take)
                sample <= { shift, sd };            // Held until the next frame
        end

    assign bus.sample       = sample;
    assign bus.sample_valid = sample_valid;
    assign value            = sample;

endmodule

//--- level_meter.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

module level_meter
(
    input  logic      clk,
    input  logic      rst,
    meter_if.meter    bus
);

    logic [`LAB_W_LEVEL - 1:0]  top;
    logic [`LAB_W_LEVEL - 1:0]  abs_level;
    logic [`LAB_W_LEVEL - 1:0]  level_q;
    logic [`LAB_W_LEVEL - 1:0]  peak_q;
    logic                       update;

    assign top    = bus.sample [`LAB_W_SAMPLE - 1 -: `LAB_W_LEVEL];
    assign update = bus.sample_valid & ~ bus.hold;  // Samples during hold are dropped

    always_comb
    begin
        if (top == { 1'b1, {(`LAB_W_LEVEL - 1){1'b0}} })
            abs_level = { 1'b0, {(`LAB_W_LEVEL - 1){1'b1}} };   // Saturate at 7FFF
        else if (top [`LAB_W_LEVEL - 1])
            abs_level = ~ top + `LAB_W_LEVEL'(1);
        else
            abs_level = top;
    end

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            level_q <= '0;
            peak_q  <= '0;
        end
        else
        begin
            if (update)
                level_q <= abs_level;

            if (bus.clear_peak)
                peak_q <= '0;                       // Clear wins over a new sample
            else if (update & (abs_level > peak_q))
                peak_q <= abs_level;
        end

    assign bus.level = level_q;
    assign bus.peak  = peak_q;

endmodule

//--- meter_control.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

module meter_control
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`LAB_W_KEY    - 1:0]   key,
    input  logic [`LAB_W_SW     - 1:0]   sw,
    input  logic [`LAB_W_SAMPLE - 1:0]   raw_value,
    meter_if.ctrl                        bus,
    output logic [`LAB_W_LEVEL  - 1:0]   disp_value,
    output logic [`LAB_W_DIGIT  - 1:0]   disp_dots
);

    lab_pkg::ctrl_state_t        state;
    lab_pkg::display_mode_t      mode;
    logic [`LAB_W_KEY   - 1:0]   key_q;
    logic [`LAB_W_KEY   - 1:0]   press;
    logic                        clear_q;
    logic [`LAB_W_LEVEL - 1:0]   raw_top;

    //----------------------------------------
    // Key edges and hold FSM

    assign press = key & ~ key_q;                   // Rising edge of each key

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            key_q   <= '0;
            clear_q <= 1'b0;
            state   <= lab_pkg::st_live;
        end
        else
        begin
            key_q   <= key;
            clear_q <= press [0];
            case (state)
                lab_pkg::st_live : if (press [1]) state <= lab_pkg::st_hold;
                lab_pkg::st_hold : if (press [1]) state <= lab_pkg::st_live;
                default          : state <= lab_pkg::st_live;
            endcase
        end

    assign bus.hold       = (state == lab_pkg::st_hold);
    assign bus.clear_peak = clear_q;

    //----------------------------------------
    // Display source

    always_comb
        case (sw [1:0])
            2'd1    : mode = lab_pkg::mode_level;
            2'd2    : mode = lab_pkg::mode_peak;
            default : mode = lab_pkg::mode_raw;     // Code 3 shows raw too
        endcase

    assign raw_top = raw_value [`LAB_W_SAMPLE - 1 -: `LAB_W_LEVEL];

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            disp_value <= '0;
            disp_dots  <= '0;
        end
        else
        begin
            case (mode)
                lab_pkg::mode_level : disp_value <= bus.level;
                lab_pkg::mode_peak  : disp_value <= bus.peak;
                default             : disp_value <= raw_top;
            endcase
            disp_dots <= { state == lab_pkg::st_hold, mode == lab_pkg::mode_peak,
                           mode == lab_pkg::mode_level, mode == lab_pkg::mode_raw };
        end

endmodule

//--- seg_scan.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

module seg_scan
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`LAB_W_LEVEL - 1:0]    value,
    input  logic [`LAB_W_DIGIT - 1:0]    dots,
    output logic [7:0]                   abcdefgh,   // h is the decimal point
    output logic [`LAB_W_DIGIT - 1:0]    digit       // One-hot
);

    localparam w_tick = $clog2 (`LAB_SCAN_DIV + 1);

    logic [w_tick - 1:0]  tick_cnt;
    logic                 tick;
    logic [3:0]           nibble;
    logic                 dot;
    logic [6:0]           segs;                      // abcdefg

    //----------------------------------------
    // Scan timing

    assign tick = (tick_cnt == w_tick'(`LAB_SCAN_DIV - 1));

    always_ff @ (posedge clk or posedge rst)
        if (rst)
        begin
            tick_cnt <= '0;
            digit    <= `LAB_W_DIGIT'(1);
        end
        else if (tick)
        begin
            tick_cnt <= '0;
            digit    <= { digit [`LAB_W_DIGIT - 2:0], digit [`LAB_W_DIGIT - 1] };
        end
        else
        begin
            tick_cnt <= tick_cnt + w_tick'(1);
        end

    //----------------------------------------
    // Nibble select and font

    always_comb
    begin
        nibble = '0;
        dot    = 1'b0;
        for (int i = 0; i < `LAB_W_DIGIT; i++)
            if (digit [i])
            begin
                nibble = value [i * 4 +: 4];
                dot    = dots [i];
            end
    end

    always_comb
        case (nibble)
            4'h0 : segs = 7'b1111110;
            4'h1 : segs = 7'b0110000;
            4'h2 : segs = 7'b1101101;
            4'h3 : segs = 7'b1111001;
            4'h4 : segs = 7'b0110011;
            4'h5 : segs = 7'b1011011;
            4'h6 : segs = 7'b1011111;
            4'h7 : segs = 7'b1110000;
            4'h8 : segs = 7'b1111111;
            4'h9 : segs = 7'b1111011;
            4'ha : segs = 7'b1110111;
            4'hb : segs = 7'b0011111;
            4'hc : segs = 7'b1001110;
            4'hd : segs = 7'b0111101;
            4'he : segs = 7'b1001111;
            default : segs = 7'b1000111;             // F
        endcase

    assign abcdefgh = { segs, dot };

endmodule

//--- static_seg_latch.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

module static_seg_latch
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [7:0]                  abcdefgh,
    input  logic [`LAB_W_DIGIT - 1:0]   digit,
    output logic [6:0]                  hex0,       // Active low
    output logic [6:0]                  hex1,
    output logic [6:0]                  hex2,
    output logic [6:0]                  hex3,
    output logic [`LAB_W_DIGIT - 1:0]   dp          // Active high LEDs
);

    logic [7:0]  hgfedcba;
    logic [6:0]  hex [`LAB_W_DIGIT];

    always_comb
        for (int i = 0; i < 8; i++)
            hgfedcba [i] = abcdefgh [7 - i];

    generate
        if (`EMULATE_DYNAMIC_SEG)
        begin : g_dynamic
            // Digits light only while scanned, so the display looks dim
            always_comb
                for (int i = 0; i < `LAB_W_DIGIT; i++)
                begin
                    hex [i] = digit [i] ? ~ hgfedcba [6:0] : '1;
                    dp  [i] = digit [i] & hgfedcba [7];
                end
        end
        else
        begin : g_static
            always_ff @ (posedge clk or posedge rst)
                if (rst)
                begin
                    hex <= '{ default: '1 };        // Blank
                    dp  <= '0;
                end
                else
                    for (int i = 0; i < `LAB_W_DIGIT; i++)
                        if (digit [i])
                        begin
                            hex [i] <= ~ hgfedcba [6:0];
                            dp  [i] <= hgfedcba [7];
                        end
        end
    endgenerate

    assign hex0 = hex [0];
    assign hex1 = hex [1];
    assign hex2 = hex [2];
    assign hex3 = hex [3];

endmodule

//--- board_top.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

module board_top
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`LAB_W_KEY   - 1:0]   key,        // Pressed is low
    input  logic [`LAB_W_SW    - 1:0]   sw,
    input  logic                        mic_sd,
    output logic                        mic_sck,
    output logic                        mic_ws,
    output logic                        mic_lr,
    output logic [6:0]                  hex0,
    output logic [6:0]                  hex1,
    output logic [6:0]                  hex2,
    output logic [6:0]                  hex3,
    output logic [`LAB_W_DIGIT - 1:0]   ledr_dp     // Decimal points on red LEDs
);

    logic [`LAB_W_KEY    - 1:0]  top_key;
    logic [`LAB_W_SAMPLE - 1:0]  mic_value;
    logic [`LAB_W_LEVEL  - 1:0]  disp_value;
    logic [`LAB_W_DIGIT  - 1:0]  disp_dots;
    logic [7:0]                  abcdefgh;
    logic [`LAB_W_DIGIT  - 1:0]  digit;

    assign top_key = ~ key;                          // Board keys are active low

    meter_if bus ();

    //----------------------------------------
    // Audio path

    mic_i2s_receiver i_mic
    (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .sd         ( mic_sd      ),
        .sck        ( mic_sck     ),
        .ws         ( mic_ws      ),
        .lr         ( mic_lr      ),
        .bus        ( bus         ),
        .value      ( mic_value   )
    );

    level_meter i_meter (.clk (clk), .rst (rst), .bus (bus));

    meter_control i_ctrl
    (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .key        ( top_key     ),
        .sw         ( sw          ),
        .raw_value  ( mic_value   ),
        .bus        ( bus         ),
        .disp_value ( disp_value  ),
        .disp_dots  ( disp_dots   )
    );

    //----------------------------------------
    // Display path

    seg_scan i_scan
    (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .value      ( disp_value  ),
        .dots       ( disp_dots   ),
        .abcdefgh   ( abcdefgh    ),
        .digit      ( digit       )
    );

    static_seg_latch i_latch
    (
        .clk        ( clk         ),
        .rst        ( rst         ),
        .abcdefgh   ( abcdefgh    ),
        .digit      ( digit       ),
        .hex0       ( hex0        ),
        .hex1       ( hex1        ),
        .hex2       ( hex2        ),
        .hex3       ( hex3        ),
        .dp         ( ledr_dp     )
    );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
    output logic  clk,
    output logic  rst
);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~ clk;                    // 40 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (10) @ (posedge clk);
        #5 rst = 1'b0;                              // Released off the clock edge
    end

endmodule

//--- tb_mic_model.sv
`timescale 1ns/10ps

module tb_mic_model
(
    input  logic          sck,
    input  logic          ws,
    input  logic [23:0]   next_word,
    input  logic          load,                 // Rising edge queues next_word
    output logic          sd,
    output int            words_done            // Queued words fully sent
);

    logic [23:0]  fifo [$];
    logic [23:0]  bits;
    logic [23:0]  word;                         // Repeated while the queue is empty
    logic         popped;
    logic         ws_q;
    int           slot;                         // sck period since ws fell

    initial
    begin
        sd         = 1'b0;
        words_done = 0;
        word       = '0;
        bits       = '0;
        popped     = 1'b0;
        ws_q       = 1'b0;
        slot       = 0;
    end

    always @ (posedge load)
        fifo.push_back (next_word);

    // Like the real mic, sd changes just after the falling sck edge
    always @ (negedge sck)
    begin
        #1;
        if (ws)
            slot = -1;                          // Right slot, mic stays quiet
        else if (ws_q)
            slot = 0;
        else
            slot = slot + 1;
        ws_q = ws;

        if (slot == 0 && fifo.size () > 0)
        begin
            word   = fifo.pop_front ();
            popped = 1'b1;
        end
        if (slot == 0)
            bits = word;

        if (slot >= 1 && slot <= 24)
        begin
            sd   = bits [23];                   // MSB first
            bits = bits << 1;
        end
        else
            sd = 1'b0;

        if (slot == 25 && popped)
        begin
            words_done = words_done + 1;
            popped     = 1'b0;
        end
    end

endmodule

//--- tb_board_top.sv
`timescale 1ns/10ps
`include "lab_defines.svh"

module tb_board_top;

    localparam int settle_cycles  = 5 * `LAB_SCAN_DIV;
    localparam int sample_timeout = 4000;          // clk cycles, about 8 frames
    localparam int reset_timeout  = 2000;          // 1 ns steps

    logic                          clk;
    logic                          rst;
    logic [`LAB_W_KEY   - 1:0]     key;
    logic [`LAB_W_SW    - 1:0]     sw;
    logic                          mic_sd;
    logic                          mic_sck;
    logic                          mic_ws;
    logic                          mic_lr;
    logic [6:0]                    hex0;
    logic [6:0]                    hex1;
    logic [6:0]                    hex2;
    logic [6:0]                    hex3;
    logic [`LAB_W_DIGIT - 1:0]     ledr_dp;
    logic [23:0]                   next_word;
    logic                          load;
    int                            words_done;
    int                            words_sent;
    int                            tests;
    int                            checks;
    int                            errors;
    int                            checks_start;
    int                            errors_start;
    string                         test_name;
    integer                        seed;

    tb_clock_gen clock_gen (.clk (clk), .rst (rst));

    tb_mic_model mic
    (
        .sck        ( mic_sck     ),
        .ws         ( mic_ws      ),
        .next_word  ( next_word   ),
        .load       ( load        ),
        .sd         ( mic_sd      ),
        .words_done ( words_done  )
    );

    board_top dut
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key     ( key     ),
        .sw      ( sw      ),
        .mic_sd  ( mic_sd  ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  ),
        .mic_lr  ( mic_lr  ),
        .hex0    ( hex0    ),
        .hex1    ( hex1    ),
        .hex2    ( hex2    ),
        .hex3    ( hex3    ),
        .ledr_dp ( ledr_dp )
    );

    //----------------------------------------
    // Reference font and level rule

    // Active-low gfedcba pattern of each hex digit
    function automatic logic [6:0] font (input logic [3:0] n);
        case (n)
            4'h0    : return ~ 7'h3f;
            4'h1    : return ~ 7'h06;
            4'h2    : return ~ 7'h5b;
            4'h3    : return ~ 7'h4f;
            4'h4    : return ~ 7'h66;
            4'h5    : return ~ 7'h6d;
            4'h6    : return ~ 7'h7d;
            4'h7    : return ~ 7'h07;
            4'h8    : return ~ 7'h7f;
            4'h9    : return ~ 7'h6f;
            4'ha    : return ~ 7'h77;
            4'hb    : return ~ 7'h7c;
            4'hc    : return ~ 7'h39;
            4'hd    : return ~ 7'h5e;
            4'he    : return ~ 7'h79;
            default : return ~ 7'h71;
        endcase
    endfunction

    function automatic int decode_digit (input logic [6:0] seg);
        for (int n = 0; n < 16; n++)
            if (font (4'(n)) == seg)
                return n;
        return -1;                                  // Not a hex digit
    endfunction

    // Absolute value of the signed top 16 bits, saturated
    function automatic logic [15:0] expected_level (input logic [23:0] w);
        int v;
        v = int'($signed (w [23:8]));
        if (v < 0)
            v = -v;
        if (v > 32767)
            v = 32767;
        return v [15:0];
    endfunction

    //----------------------------------------
    // Drivers, waits and checks

    task automatic stop_on_timeout (input string what);
        $display ("Timeout while waiting for %s in test %s", what, test_name);
        $display ("RESULT: FAIL");
        $finish;
    endtask

    task automatic set_switches (input logic [7:0] v);
        @ (posedge clk);
        #5 sw = v;
    endtask

    task automatic press_key (input logic [1:0] idx);
        @ (posedge clk);
        #5 key [idx] = 1'b0;                        // Board keys are active low
        repeat (3) @ (posedge clk);
        #5 key [idx] = 1'b1;
    endtask

    task automatic send_sample (input logic [23:0] w);
        int n;
        next_word = w;
        load      = 1'b1;
        #1 load   = 1'b0;
        words_sent++;
        n = 0;
        while (words_done < words_sent)
        begin
            @ (posedge clk);
            n++;
            if (n > sample_timeout)
                stop_on_timeout ("a mic sample to be sent");
        end
    endtask

    task automatic settle;
        repeat (settle_cycles) @ (posedge clk);
        #5;
    endtask

    task automatic check_blank;
        logic [6:0] segs [4];
        segs = '{ hex0, hex1, hex2, hex3 };
        for (int i = 0; i < 4; i++)
        begin
            checks++;
            assert (segs [i] == 7'h7f)
            else
            begin
                $display ("Fail %s: hex%0d 0x%h, expected 0x7f", test_name, i, segs [i]);
                errors++;
            end
        end
        checks++;
        assert (ledr_dp == 4'h0)
        else
        begin
            $display ("Fail %s: ledr_dp 0x%h, expected 0x0", test_name, ledr_dp);
            errors++;
        end
    endtask

    task automatic check_display (input logic [15:0] value, input logic [3:0] dots);
        logic [6:0]   segs [4];
        logic [15:0]  shown;
        int           d;
        segs  = '{ hex0, hex1, hex2, hex3 };
        shown = '0;
        for (int i = 0; i < 4; i++)
        begin
            d = decode_digit (segs [i]);
            checks++;
            assert (d >= 0)
            else
            begin
                $display ("Digit %0d shows pattern %h, which is no hex digit", i, segs [i]);
                errors++;
            end
            shown [i * 4 +: 4] = 4'(d);
        end
        checks++;
        assert (shown == value)
        else
        begin
            $display ("Fail %s: hex3..hex0 0x%h, expected 0x%h", test_name, shown, value);
            errors++;
        end
        checks++;
        assert (ledr_dp == dots)
        else
        begin
            $display ("Fail %s: ledr_dp 0x%h, expected 0x%h", test_name, ledr_dp, dots);
            errors++;
        end
    endtask

    task automatic begin_test (input string name);
        test_name    = name;
        checks_start = checks;
        errors_start = errors;
        tests++;
    endtask

    task automatic end_test;
        $display ("Test %s done: %0d checks, %0d errors", test_name,
                  checks - checks_start, errors - errors_start);
    endtask

    //----------------------------------------
    // Tests

    task automatic test_reset;
        int n;
        begin_test ("reset");
        repeat (3) @ (posedge clk);
        #5;
        check_blank;                                // Still in reset
        n = 0;
        while (rst)
        begin
            #1;
            n++;
            if (n > reset_timeout)
                stop_on_timeout ("reset release");
        end
        check_blank;                                // Before the first scan edge
        checks++;
        assert (mic_lr == 1'b0)
        else
        begin
            $display ("Fail %s: mic_lr 0x%h, expected 0x0", test_name, mic_lr);
            errors++;
        end
        end_test;
    endtask

    task automatic test_raw;
        logic [31:0]  r;
        logic [23:0]  words [5];
        begin_test ("raw");
        words [0] = 24'h123456;
        words [1] = 24'habcdef;
        for (int i = 2; i < 5; i++)
        begin
            r         = $random (seed);
            words [i] = r [23:0];
        end
        set_switches (8'd0);
        for (int i = 0; i < 5; i++)
        begin
            send_sample (words [i]);
            settle;
            check_display (words [i][23:8], 4'b0001);
        end
        end_test;
    endtask

    task automatic test_level;
        logic [31:0]  r;
        logic [23:0]  words [6];
        begin_test ("level");
        words [0] = 24'hff0000;
        words [1] = 24'h800000;                     // Most negative, saturates
        words [2] = 24'h7fff00;
        words [3] = 24'h123400;
        for (int i = 4; i < 6; i++)
        begin
            r         = $random (seed);
            words [i] = { 1'b1, r [22:0] };         // Force negative
        end
        set_switches (8'd1);
        for (int i = 0; i < 6; i++)
        begin
            send_sample (words [i]);
            settle;
            check_display (expected_level (words [i]), 4'b0010);
        end
        end_test;
    endtask

    task automatic test_peak;
        logic [23:0]  words [5];
        logic [15:0]  peak;
        begin_test ("peak");
        words [0] = 24'h100000;
        words [1] = 24'hf00000;
        words [2] = 24'h5a5a00;
        words [3] = 24'hc30000;
        words [4] = 24'h001200;
        set_switches (8'd2);
        send_sample (24'h000100);                   // Quiet word before the clear
        press_key (2'd0);
        peak = '0;
        for (int i = 0; i < 5; i++)
        begin
            send_sample (words [i]);
            if (expected_level (words [i]) > peak)
                peak = expected_level (words [i]);
        end
        settle;
        check_display (peak, 4'b0100);
        press_key (2'd0);
        send_sample (24'h001200);
        settle;
        check_display (expected_level (24'h001200), 4'b0100);
        end_test;
    endtask

    task automatic test_hold;
        begin_test ("hold");
        set_switches (8'd1);
        send_sample (24'h2a0000);
        settle;
        check_display (16'h2a00, 4'b0010);
        press_key (2'd1);
        settle;
        check_display (16'h2a00, 4'b1010);
        send_sample (24'hc00000);                   // Dropped while holding
        settle;
        check_display (16'h2a00, 4'b1010);
        press_key (2'd1);
        send_sample (24'h0abc00);
        settle;
        check_display (expected_level (24'h0abc00), 4'b0010);
        end_test;
    endtask

    initial
    begin
        key        = '1;
        sw         = '0;
        next_word  = '0;
        load       = 1'b0;
        words_sent = 0;
        tests      = 0;
        checks     = 0;
        errors     = 0;
        seed       = 32'h6959_b258;

        test_reset;
        test_raw;
        test_level;
        test_peak;
        test_hold;

        $display ("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display ("RESULT: PASS");
        else
            $display ("RESULT: FAIL");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
lab_pkg.sv
meter_if.sv
mic_i2s_receiver.sv
level_meter.sv
meter_control.sv
seg_scan.sv
static_seg_latch.sv
board_top.sv
tb_clock_gen.sv
tb_mic_model.sv
tb_board_top.sv

//--- run.sh
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert --top-module tb_board_top -f list.f > build.log 2>&1 \
    && ./obj_dir/Vtb_board_top > sim.log 2>&1 \
    && grep -qx "RESULT: PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
